// ==== hdl/fifo_bank_macros.svh ====
`ifndef FIFO_BANK_MACROS_SVH
`define FIFO_BANK_MACROS_SVH

// Bank geometry
`define FB_CHANNELS       4
`define FB_CH_WIDTH       2
`define FB_DATA_WIDTH     16

// Per-channel FIFO sizing
// The depth must be a power of two
`define FB_FIFO_DEPTH     16
`define FB_FIFO_AFULL     12

// APB address map
`define FB_APB_ADDR_WIDTH 8
`define FB_STATUS_ADDR    8'h40
// Channel n is pushed at n times the stride
`define FB_PUSH_STRIDE    4

`endif

// ==== hdl/fifo_bank_pkg.sv ====
`default_nettype none

`include "fifo_bank_macros.svh"

package fifo_bank_pkg;

  // Push request from the APB port, valid for one wr_clk cycle
  typedef struct packed {
    logic                      valid;
    logic [`FB_CH_WIDTH-1:0]   channel;
    logic [`FB_DATA_WIDTH-1:0] data;
  } fb_push_t;

  // Registered write-side flags of one channel
  typedef struct packed {
    logic full;
    logic afull;
  } fb_flags_t;

  // Word on the output stream, tagged with its source channel
  typedef struct packed {
    logic [`FB_CH_WIDTH-1:0]   channel;
    logic [`FB_DATA_WIDTH-1:0] data;
  } fb_drain_t;

endpackage

`default_nettype wire

// ==== hdl/dual_port_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

module dual_port_ram #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 4
) (
  input  wire                  wr_clk,
  input  wire                  wr_en,
  input  wire [ADDR_WIDTH-1:0] wr_addr,
  input  wire [DATA_WIDTH-1:0] wr_data,
  input  wire                  rd_clk,
  input  wire                  rd_en,
  input  wire [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data stays put between pops
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/async_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

module async_fifo #(
  parameter int DATA_WIDTH = 16,
  parameter int DEPTH      = 16,
  parameter int AFULL      = 12,
  parameter int CHANNEL    = 0
) (
  input  wire                       wr_clk,
  input  wire                       wr_rst_n,
  input  wire fifo_bank_pkg::fb_push_t push,
  input  wire                       rd_clk,
  input  wire                       rd_rst_n,
  input  wire                       pop,
  output fifo_bank_pkg::fb_flags_t  flags,
  output logic                      empty,
  output wire [DATA_WIDTH-1:0]      rd_data
);

  localparam int AW = $clog2(DEPTH);

  logic          wr_en;
  logic [AW:0]   wr_bin;
  logic [AW:0]   wr_bin_nxt;
  logic [AW:0]   wr_gray;
  logic [AW:0]   wr_gray_nxt;
  logic [AW:0]   rd_gray_w1;
  logic [AW:0]   rd_gray_w2;
  logic [AW:0]   rd_bin_w;
  logic [AW:0]   used_nxt;
  logic [AW:0]   wr_used;

  logic          rd_en;
  logic [AW:0]   rd_bin;
  logic [AW:0]   rd_bin_nxt;
  logic [AW:0]   rd_gray;
  logic [AW:0]   rd_gray_nxt;
  logic [AW:0]   wr_gray_r1;
  logic [AW:0]   wr_gray_r2;

  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign wr_en = push.valid && (int'(push.channel) == CHANNEL) && !flags.full;
  assign rd_en = pop && !empty;

  dual_port_ram #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(AW)
  ) u_ram (
    .wr_clk (wr_clk),
    .wr_en  (wr_en),
    .wr_addr(wr_bin[AW-1:0]),
    .wr_data(push.data),
    .rd_clk (rd_clk),
    .rd_en  (rd_en),
    .rd_addr(rd_bin[AW-1:0]),
    .rd_data(rd_data)
  );

  // Write domain
  assign wr_bin_nxt  = wr_bin + {{AW{1'b0}}, wr_en};
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);
  assign rd_bin_w    = gray2bin(rd_gray_w2);
  assign used_nxt    = wr_bin_nxt - rd_bin_w;
  assign wr_used     = wr_bin - rd_bin_w;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      flags      <= '0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= wr_gray_nxt;
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      // Full when the pointers differ only in the wrap and next bits
      flags.full  <= (wr_gray_nxt == {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});
      flags.afull <= (used_nxt >= AFULL);
    end
  end

  // Read domain
  assign rd_bin_nxt  = rd_bin + {{AW{1'b0}}, rd_en};
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      empty      <= 1'b1;
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= rd_gray_nxt;
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      empty      <= (rd_gray_nxt == wr_gray_r2);
    end
  end

  // Occupancy seen through the synced read pointer never exceeds the depth
  a_no_overflow: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_en |-> (wr_used < DEPTH));

  // The arbiter only pops a channel it sees as non-empty
  a_no_underflow: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    pop |-> !empty);

  a_wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1);

  a_rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1);

endmodule

`default_nettype wire

// ==== hdl/apb_push_port.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "fifo_bank_macros.svh"

module apb_push_port (
  input  wire                           wr_clk,
  input  wire                           wr_rst_n,
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire [`FB_APB_ADDR_WIDTH-1:0]  paddr,
  input  wire [`FB_DATA_WIDTH-1:0]      pwdata,
  input  wire fifo_bank_pkg::fb_flags_t flags [`FB_CHANNELS],
  output logic [`FB_DATA_WIDTH-1:0]     prdata,
  output logic                          pready,
  output logic                          pslverr,
  output fifo_bank_pkg::fb_push_t       push
);

  logic                          access;
  logic [`FB_APB_ADDR_WIDTH-1:0] ch_idx;
  logic [`FB_CH_WIDTH-1:0]       ch_sel;
  logic                          push_addr;
  logic                          status_addr;
  logic                          ch_full;
  logic                          push_ok;
  logic [`FB_DATA_WIDTH-1:0]     status;

  assign access = psel && penable;

  // Push addresses sit on stride boundaries below the channel count
  assign ch_idx      = paddr / `FB_APB_ADDR_WIDTH'(`FB_PUSH_STRIDE);
  assign ch_sel      = ch_idx[`FB_CH_WIDTH-1:0];
  assign push_addr   = (paddr % `FB_APB_ADDR_WIDTH'(`FB_PUSH_STRIDE) == '0) &&
                       (ch_idx < `FB_CHANNELS);
  assign status_addr = (paddr == `FB_STATUS_ADDR);
  assign ch_full     = flags[ch_sel].full;

  assign push_ok = access && pwrite && push_addr && !ch_full;

  always_comb begin
    status = '0;
    for (int n = 0; n < `FB_CHANNELS; n++) begin
      status[2*n]   = flags[n].full;
      status[2*n+1] = flags[n].afull;
    end
  end

  // Without wait states every transfer finishes in its ACCESS cycle
  assign pready  = 1'b1;
  assign pslverr = access && (pwrite ? !push_ok : !status_addr);
  assign prdata  = (access && !pwrite && status_addr) ? status : '0;

  always_comb begin
    push.valid   = push_ok;
    push.channel = ch_sel;
    push.data    = pwdata;
  end

  // A push lasts exactly one cycle because penable drops after every ACCESS phase
  a_push_one_cycle: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    push.valid |=> !push.valid);

endmodule

`default_nettype wire

// ==== hdl/drain_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "fifo_bank_macros.svh"

module drain_arbiter (
  input  wire                       rd_clk,
  input  wire                       rd_rst_n,
  input  wire [`FB_CHANNELS-1:0]    empty,
  input  wire [`FB_DATA_WIDTH-1:0]  rd_data [`FB_CHANNELS],
  input  wire                       out_ready,
  output logic [`FB_CHANNELS-1:0]   pop,
  output logic                      out_valid,
  output fifo_bank_pkg::fb_drain_t  out
);

  logic [`FB_CH_WIDTH-1:0] rr_ptr;
  logic [`FB_CH_WIDTH-1:0] grant_ch;
  logic                    grant_any;
  logic                    can_pop;
  logic                    pop_fire;
  logic                    pending;
  logic [`FB_CH_WIDTH-1:0] pend_ch;

  // Scan downwards so the nearest channel after rr_ptr wins
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_ch  = rr_ptr;
    for (int k = `FB_CHANNELS; k >= 1; k--) begin
      idx = (int'(rr_ptr) + k) % `FB_CHANNELS;
      if (!empty[idx]) begin
        grant_any = 1'b1;
        grant_ch  = idx[`FB_CH_WIDTH-1:0];
      end
    end
  end

  // At most one word is in flight and the output slot must be free by capture time
  assign can_pop  = !pending && (!out_valid || out_ready);
  assign pop_fire = can_pop && grant_any;

  always_comb begin
    pop = '0;
    if (pop_fire) begin
      pop[grant_ch] = 1'b1;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rr_ptr    <= `FB_CH_WIDTH'(`FB_CHANNELS - 1);
      pending   <= 1'b0;
      pend_ch   <= '0;
      out_valid <= 1'b0;
    end else begin
      pending <= pop_fire;
      if (pop_fire) begin
        rr_ptr  <= grant_ch;
        pend_ch <= grant_ch;
      end
      if (pending) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // RAM output is valid the cycle after the pop
  always_ff @(posedge rd_clk) begin
    if (pending) begin
      out.channel <= pend_ch;
      out.data    <= rd_data[pend_ch];
    end
  end

  a_out_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

`default_nettype wire

// ==== hdl/fifo_bank_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "fifo_bank_macros.svh"

module fifo_bank_top (
  input  wire                          wr_clk,
  input  wire                          wr_rst_n,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [`FB_APB_ADDR_WIDTH-1:0] paddr,
  input  wire [`FB_DATA_WIDTH-1:0]     pwdata,
  input  wire                          rd_clk,
  input  wire                          rd_rst_n,
  input  wire                          out_ready,
  output wire [`FB_DATA_WIDTH-1:0]     prdata,
  output wire                          pready,
  output wire                          pslverr,
  output wire                          out_valid,
  output wire fifo_bank_pkg::fb_drain_t out
);

  wire fifo_bank_pkg::fb_push_t  push;
  wire fifo_bank_pkg::fb_flags_t flags [`FB_CHANNELS];
  wire [`FB_CHANNELS-1:0]        empty;
  wire [`FB_CHANNELS-1:0]        pop;
  wire [`FB_DATA_WIDTH-1:0]      rd_data [`FB_CHANNELS];

  apb_push_port u_apb (
    .wr_clk  (wr_clk),
    .wr_rst_n(wr_rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .flags   (flags),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .push    (push)
  );

  // All channels see the same push and each keeps only its own channel number
  for (genvar i = 0; i < `FB_CHANNELS; i++) begin : g_ch
    async_fifo #(
      .DATA_WIDTH(`FB_DATA_WIDTH),
      .DEPTH     (`FB_FIFO_DEPTH),
      .AFULL     (`FB_FIFO_AFULL),
      .CHANNEL   (i)
    ) u_fifo (
      .wr_clk  (wr_clk),
      .wr_rst_n(wr_rst_n),
      .push    (push),
      .rd_clk  (rd_clk),
      .rd_rst_n(rd_rst_n),
      .pop     (pop[i]),
      .flags   (flags[i]),
      .empty   (empty[i]),
      .rd_data (rd_data[i])
    );
  end

  drain_arbiter u_arb (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .empty    (empty),
    .rd_data  (rd_data),
    .out_ready(out_ready),
    .pop      (pop),
    .out_valid(out_valid),
    .out      (out)
  );

endmodule

`default_nettype wire

// ==== verification/fifo_bank_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "fifo_bank_macros.svh"

module fifo_bank_tb;

  localparam int OP_PUSH    = 0;
  localparam int OP_STATUS  = 1;
  localparam int OP_POLL    = 2;
  localparam int OP_BAD     = 3;
  localparam int OP_READY   = 4;
  localparam int OP_DRAIN   = 5;
  localparam int ERR_ANY    = 2;
  localparam int READY_LOW  = 0;
  localparam int READY_HIGH = 1;
  localparam int READY_RAND = 2;
  localparam int READY_FAIR = 3;

  // For OP_BAD the channel field selects write (1) or read (0) and data holds the address
  typedef struct packed {
    logic [2:0]                op;
    logic [`FB_CH_WIDTH-1:0]   ch;
    logic [`FB_DATA_WIDTH-1:0] data;
    logic [1:0]                exp_err;
  } step_t;

  logic                          wr_clk;
  logic                          wr_rst_n;
  logic                          rd_clk;
  logic                          rd_rst_n;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [`FB_APB_ADDR_WIDTH-1:0] paddr;
  logic [`FB_DATA_WIDTH-1:0]     pwdata;
  logic                          out_ready;
  wire  [`FB_DATA_WIDTH-1:0]     prdata;
  wire                           pready;
  wire                           pslverr;
  wire                           out_valid;
  wire fifo_bank_pkg::fb_drain_t out_word;

  step_t                     steps [128];
  int                        n_steps;
  bit                        table_ready;
  logic [31:0]               rng;
  int                        ready_mode;
  int                        errors;
  int                        checks;
  logic [`FB_DATA_WIDTH-1:0] ref_mem [`FB_CHANNELS][256];
  int                        head [`FB_CHANNELS];
  int                        tail [`FB_CHANNELS];
  int                        tries [`FB_CHANNELS];
  bit                        rejected [`FB_CHANNELS];
  int                        fair_left;
  int                        fair_prev;

  fifo_bank_top uut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .out_ready(out_ready),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .out_valid(out_valid),
    .out      (out_word)
  );

  always #50 wr_clk = ~wr_clk;
  always #65 rd_clk = ~rd_clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = lcg(rng);
    return rng;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic add_step(input int op, input int ch, input logic [15:0] data, input int err);
    steps[n_steps].op      = 3'(op);
    steps[n_steps].ch      = `FB_CH_WIDTH'(ch);
    steps[n_steps].data    = data;
    steps[n_steps].exp_err = 2'(err);
    n_steps++;
  endtask

  task automatic build_table();
    logic [31:0] w;
    add_step(OP_STATUS, 0, 16'h0000, 0);
    add_step(OP_READY, 0, READY_RAND, 0);
    for (int i = 0; i < 16; i++) begin
      w = rand_word();
      add_step(OP_PUSH, int'(w[31:30]), rand_word() >> 16, 0);
    end
    add_step(OP_DRAIN, 0, 0, 0);
    // Channel 1 fills while the output is stalled and one word sits in the output register
    add_step(OP_READY, 0, READY_LOW, 0);
    for (int i = 0; i < 14; i++) begin
      w = rand_word();
      add_step(OP_PUSH, 1, w[31:16], 0);
    end
    add_step(OP_POLL, 1, 16'b10, 0);
    for (int i = 0; i < 4; i++) begin
      w = rand_word();
      add_step(OP_PUSH, 1, w[31:16], ERR_ANY);
    end
    add_step(OP_POLL, 1, 16'b11, 0);
    add_step(OP_PUSH, 1, 16'h5a5a, 1);
    add_step(OP_BAD, 1, 16'h0040, 1);
    add_step(OP_BAD, 1, 16'h0044, 1);
    add_step(OP_BAD, 1, 16'h0002, 1);
    add_step(OP_BAD, 1, 16'h0010, 1);
    add_step(OP_BAD, 0, 16'h0024, 1);
    add_step(OP_BAD, 0, 16'h0004, 1);
    add_step(OP_READY, 0, READY_HIGH, 0);
    add_step(OP_DRAIN, 0, 0, 0);
    add_step(OP_POLL, 1, 16'b00, 0);
    add_step(OP_READY, 0, READY_LOW, 0);
    for (int i = 0; i < 20; i++) begin
      w = rand_word();
      add_step(OP_PUSH, i % `FB_CHANNELS, w[31:16], 0);
    end
    add_step(OP_READY, 0, READY_FAIR, 0);
    add_step(OP_DRAIN, 0, 0, 0);
    add_step(OP_STATUS, 0, 16'h0000, 0);
  endtask

  // One APB transfer with an idle cycle after it and the responses sampled mid ACCESS
  task automatic apb_xfer(input logic wr, input logic [`FB_APB_ADDR_WIDTH-1:0] addr,
                          input logic [`FB_DATA_WIDTH-1:0] wdata, output logic err,
                          output logic [`FB_DATA_WIDTH-1:0] rdata);
    @(posedge wr_clk);
    #10;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge wr_clk);
    #10;
    penable = 1'b1;
    @(negedge wr_clk);
    check("pready", pready, 1);
    err   = pslverr;
    rdata = prdata;
    @(posedge wr_clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic bit all_drained();
    for (int c = 0; c < `FB_CHANNELS; c++) begin
      if (head[c] != tail[c]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic apply_step(input step_t st);
    logic                      err;
    logic [`FB_DATA_WIDTH-1:0] rdata;
    bit                        hit;
    int                        ch;
    ch = int'(st.ch);
    case (int'(st.op))
      OP_PUSH: begin
        apb_xfer(1'b1, `FB_APB_ADDR_WIDTH'(ch * `FB_PUSH_STRIDE), st.data, err, rdata);
        tries[ch]++;
        if (st.exp_err != ERR_ANY) begin
          check("pslverr", err, st.exp_err);
        end
        if (!err) begin
          ref_mem[ch][tail[ch]] = st.data;
          tail[ch]++;
        end else if (!rejected[ch]) begin
          rejected[ch] = 1'b1;
          if (tries[ch] > `FB_FIFO_DEPTH + 2) begin
            errors++;
            $display("Channel %0d first refused a push at attempt %0d, too late", ch, tries[ch]);
          end
        end
      end
      OP_STATUS: begin
        apb_xfer(1'b0, `FB_STATUS_ADDR, '0, err, rdata);
        check("pslverr", err, 0);
        check("prdata", rdata, st.data);
      end
      OP_POLL: begin
        hit = 1'b0;
        for (int k = 0; k < 40 && !hit; k++) begin
          apb_xfer(1'b0, `FB_STATUS_ADDR, '0, err, rdata);
          check("pslverr", err, 0);
          hit = ({rdata[2*ch+1], rdata[2*ch]} == st.data[1:0]);
        end
        if (!hit) begin
          errors++;
          $display("Status of channel %0d never showed %b within 40 polls", ch, st.data[1:0]);
        end
      end
      OP_BAD: begin
        apb_xfer(st.ch[0], st.data[`FB_APB_ADDR_WIDTH-1:0], 16'hbad0, err, rdata);
        check("pslverr", err, st.exp_err);
        if (!st.ch[0]) begin
          check("prdata", rdata, 0);
        end
      end
      OP_READY: begin
        if (int'(st.data) == READY_FAIR) begin
          // Let every pushed word reach the read side before releasing the output
          repeat (10) @(posedge wr_clk);
          fair_prev  = -1;
          fair_left  = 16;
          ready_mode = READY_HIGH;
        end else begin
          ready_mode = int'(st.data);
        end
      end
      default: begin
        while (!all_drained()) begin
          @(posedge wr_clk);
        end
        for (int c = 0; c < `FB_CHANNELS; c++) begin
          tries[c]    = 0;
          rejected[c] = 1'b0;
        end
      end
    endcase
  endtask

  always @(posedge rd_clk) begin
    #10;
    if (ready_mode == READY_RAND) begin
      out_ready = rand_word() >> 31;
    end else begin
      out_ready = (ready_mode == READY_HIGH);
    end
  end

  // Transfers are sampled half a cycle before the edge that completes them
  always @(negedge rd_clk) begin
    int ch;
    if (rd_rst_n && out_valid && out_ready) begin
      ch = int'(out_word.channel);
      if (head[ch] == tail[ch]) begin
        errors++;
        $display("Unexpected word %h from channel %0d at %0t", out_word.data, ch, $time);
      end else begin
        check("out.data", out_word.data, ref_mem[ch][head[ch]]);
        head[ch]++;
      end
      if (fair_left > 0) begin
        if (fair_prev >= 0) begin
          check("out.channel", ch, (fair_prev + 1) % `FB_CHANNELS);
        end
        fair_prev = ch;
        fair_left--;
      end
    end
  end

  initial begin
    wait (table_ready);
    #(n_steps * 40 * 100);
    $display("Timeout: the run did not finish within %0d wr_clk periods", n_steps * 40);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Regression failed");
    $finish;
  end

  initial begin
    wr_clk    = 1'b0;
    rd_clk    = 1'b0;
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    out_ready = 1'b0;
    rng       = 32'h39157980;
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge wr_clk);
    #10;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    check("out_valid", out_valid, 0);
    check("pslverr", pslverr, 0);
    for (int i = 0; i < n_steps; i++) begin
      apply_step(steps[i]);
    end
    repeat (20) @(posedge rd_clk);
    for (int c = 0; c < `FB_CHANNELS; c++) begin
      if (head[c] != tail[c]) begin
        errors++;
        $display("Channel %0d still owes %0d words at the end", c, tail[c] - head[c]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/fifo_bank_pkg.sv
hdl/dual_port_ram.sv
hdl/async_fifo.sv
hdl/apb_push_port.sv
hdl/drain_arbiter.sv
hdl/fifo_bank_top.sv
verification/fifo_bank_tb.sv
